// File: logic/cnn_quad_pkg.sv
`default_nettype none

package cnn_quad_pkg;

    ////////////////////
    // Array and data widths
    ////////////////////
    localparam int NUM_CE           = 4;
    localparam int PIXEL_WIDTH      = 16;
    localparam int WEIGHT_WIDTH     = 16;
    localparam int ACC_WIDTH        = 32;
    localparam int MAX_KERNEL       = 8;
    localparam int PFB_DEPTH        = 16;
    localparam int PFB_ADDR_WIDTH   = $clog2(PFB_DEPTH);
    localparam int JOB_PARAMS_WIDTH = 16;

    // Job parameter word fields
    localparam int JOB_KLEN_LSB = 0;
    localparam int JOB_KLEN_MSB = 3;
    localparam int JOB_ROWS_LSB = 4;
    localparam int JOB_ROWS_MSB = 11;
    localparam int JOB_RELU_BIT = 12;

    ////////////////////
    // Data types
    ////////////////////
    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;

    // Lane i sits at bits i*WIDTH and up
    typedef logic [NUM_CE*PIXEL_WIDTH-1:0]  pixel_word_t;
    typedef logic [NUM_CE*WEIGHT_WIDTH-1:0] weight_word_t;
    typedef logic [NUM_CE*ACC_WIDTH-1:0]    result_word_t;

    typedef logic [$clog2(MAX_KERNEL)-1:0]   tap_t;
    typedef logic [$clog2(MAX_KERNEL+1)-1:0] kernel_len_t;
    typedef logic [7:0]                      row_count_t;
    typedef logic [$clog2(PFB_DEPTH+1)-1:0]  pfb_count_t;
    typedef logic [JOB_PARAMS_WIDTH-1:0]     job_params_t;

    // Job state machine
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_JOB_DONE
    } quad_state_t;

endpackage

`default_nettype wire

// File: logic/cnn_quad_top.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_quad_top (
    input  logic                       clk_core,
    input  logic                       rst,
    input  logic                       job_start,
    output logic                       job_accept,
    input  cnn_quad_pkg::job_params_t  job_parameters,
    output logic                       job_fetch_request,
    input  logic                       job_fetch_ack,
    output logic                       job_complete,
    input  logic                       job_complete_ack,
    input  logic                       weight_valid,
    output logic                       weight_ready,
    input  cnn_quad_pkg::weight_word_t weight_data,
    input  logic                       pixel_valid,
    output logic                       pixel_ready,
    input  cnn_quad_pkg::pixel_word_t  pixel_data,
    output logic                       result_valid,
    input  logic                       result_accept,
    output cnn_quad_pkg::result_word_t result_data
);

    logic                       pfb_wr_en;
    logic                       pfb_rden;
    cnn_quad_pkg::pixel_word_t  pfb_dout;
    cnn_quad_pkg::pfb_count_t   pfb_count;
    logic                       load_enable;
    cnn_quad_pkg::tap_t         tap;
    logic                       first_tap;
    logic                       relu_en;
    cnn_quad_pkg::weight_word_t weights;

    // Beats accepted during a fetch go straight into the FIFO
    assign pfb_wr_en = pixel_valid && pixel_ready;

    quad_job_ctrl i_quad_job_ctrl (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_accept        (job_accept),
        .job_parameters    (job_parameters),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .pfb_count         (pfb_count),
        .pfb_rden          (pfb_rden),
        .load_enable       (load_enable),
        .tap               (tap),
        .first_tap         (first_tap),
        .last_tap          (),
        .relu_en           (relu_en),
        .result_valid      (result_valid),
        .result_accept     (result_accept)
    );

    prefetch_buffer_fifo i_prefetch_buffer_fifo (
        .clk_core (clk_core),
        .rst      (rst),
        .wr_en    (pfb_wr_en),
        .din      (pixel_data),
        .rd_en    (pfb_rden),
        .dout     (pfb_dout),
        .count    (pfb_count)
    );

    weight_table i_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .load_enable  (load_enable),
        .job_accept   (job_accept),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .tap          (tap),
        .weights      (weights)
    );

    ////////////////////
    // One compute engine per lane
    ////////////////////
    for (genvar i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin : g_ce
        conv_engine i_conv_engine (
            .clk_core  (clk_core),
            .rst       (rst),
            .relu_en   (relu_en),
            .first_tap (first_tap),
            .pixel     (pfb_dout[i*cnn_quad_pkg::PIXEL_WIDTH +: cnn_quad_pkg::PIXEL_WIDTH]),
            .weight    (weights[i*cnn_quad_pkg::WEIGHT_WIDTH +: cnn_quad_pkg::WEIGHT_WIDTH]),
            .acc       (result_data[i*cnn_quad_pkg::ACC_WIDTH +: cnn_quad_pkg::ACC_WIDTH])
        );
    end

endmodule

`default_nettype wire

// File: logic/conv_engine.sv
`timescale 1ns/100ps
`default_nettype none

module conv_engine (
    input  logic                  clk_core,
    input  logic                  rst,
    input  logic                  relu_en,
    input  logic                  first_tap,
    input  cnn_quad_pkg::pixel_t  pixel,
    input  cnn_quad_pkg::weight_t weight,
    output cnn_quad_pkg::acc_t    acc
);

    cnn_quad_pkg::pixel_t pixel_act;
    cnn_quad_pkg::acc_t   product;

    // Negative pixels clamp to zero under ReLU
    always_comb begin
        if (relu_en && pixel[cnn_quad_pkg::PIXEL_WIDTH-1]) begin
            pixel_act = '0;
        end else begin
            pixel_act = pixel;
        end
    end

    // Signed 16x16 product sign extended to the accumulator width
    assign product = cnn_quad_pkg::acc_t'(pixel_act) * cnn_quad_pkg::acc_t'(weight);

    ////////////////////
    // Accumulator
    ////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            acc <= '0;
        end else if (first_tap) begin
            acc <= product;
        end else begin
            // Zero product between rows keeps the result steady
            acc <= acc + product;
        end
    end

endmodule

`default_nettype wire

// File: logic/prefetch_buffer_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module prefetch_buffer_fifo (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      wr_en,
    input  cnn_quad_pkg::pixel_word_t din,
    input  logic                      rd_en,
    output cnn_quad_pkg::pixel_word_t dout,
    output cnn_quad_pkg::pfb_count_t  count
);

    cnn_quad_pkg::pixel_word_t               mem [cnn_quad_pkg::PFB_DEPTH];
    logic [cnn_quad_pkg::PFB_ADDR_WIDTH-1:0] wr_ptr;
    logic [cnn_quad_pkg::PFB_ADDR_WIDTH-1:0] rd_ptr;

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Zero between reads so the engine sums hold
    always_ff @(posedge clk_core) begin
        if (rd_en) begin
            dout <= mem[rd_ptr];
        end else begin
            dout <= '0;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow : assert property (@(posedge clk_core) disable iff (rst)
        wr_en |-> count != cnn_quad_pkg::pfb_count_t'(cnn_quad_pkg::PFB_DEPTH));

    a_no_underflow : assert property (@(posedge clk_core) disable iff (rst)
        rd_en |-> count != '0);

endmodule

`default_nettype wire

// File: logic/quad_job_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module quad_job_ctrl (
    input  logic                      clk_core,
    input  logic                      rst,
    input  logic                      job_start,
    output logic                      job_accept,
    input  cnn_quad_pkg::job_params_t job_parameters,
    output logic                      job_fetch_request,
    input  logic                      job_fetch_ack,
    output logic                      job_complete,
    input  logic                      job_complete_ack,
    input  logic                      pixel_valid,
    output logic                      pixel_ready,
    input  cnn_quad_pkg::pfb_count_t  pfb_count,
    output logic                      pfb_rden,
    output logic                      load_enable,
    output cnn_quad_pkg::tap_t        tap,
    output logic                      first_tap,
    output logic                      last_tap,
    output logic                      relu_en,
    output logic                      result_valid,
    input  logic                      result_accept
);

    cnn_quad_pkg::quad_state_t state;
    cnn_quad_pkg::kernel_len_t klen_q;
    cnn_quad_pkg::row_count_t  num_rows_q;
    cnn_quad_pkg::row_count_t  rows_requested;
    cnn_quad_pkg::row_count_t  rows_done;
    cnn_quad_pkg::kernel_len_t beats_fetched;
    cnn_quad_pkg::pfb_count_t  klen_ext;
    logic                      fetch_busy;
    logic                      row_busy;
    logic                      last_tap_d;
    logic                      job_take;
    logic                      fetch_go;
    logic                      row_go;
    logic                      tap_final;
    logic                      result_taken;

    assign load_enable  = (state == cnn_quad_pkg::ST_IDLE);
    assign job_complete = (state == cnn_quad_pkg::ST_JOB_DONE);
    assign job_take     = load_enable && job_start;
    assign klen_ext     = cnn_quad_pkg::pfb_count_t'(klen_q);
    assign pixel_ready  = fetch_busy && pixel_valid;
    assign result_taken = result_valid && result_accept;
    assign tap_final    = pfb_rden && (cnn_quad_pkg::kernel_len_t'(tap) == klen_q - 1'b1);

    // Next row fetch only when a whole kernel still fits in the FIFO
    assign fetch_go = (state == cnn_quad_pkg::ST_ACTIVE) && !fetch_busy && !job_fetch_request
                   && (rows_requested < num_rows_q)
                   && (cnn_quad_pkg::pfb_count_t'(pfb_count + klen_ext)
                       <= cnn_quad_pkg::pfb_count_t'(cnn_quad_pkg::PFB_DEPTH));

    // Row compute waits for a full kernel and a drained result
    assign row_go = (state == cnn_quad_pkg::ST_ACTIVE) && !row_busy && !result_valid
                 && (pfb_count >= klen_ext);

    ////////////////////
    // Job state machine
    ////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            state      <= cnn_quad_pkg::ST_IDLE;
            job_accept <= 1'b0;
        end else begin
            job_accept <= job_take;
            case (state)
                cnn_quad_pkg::ST_IDLE: begin
                    if (job_start) begin
                        state <= cnn_quad_pkg::ST_ACTIVE;
                    end
                end
                cnn_quad_pkg::ST_ACTIVE: begin
                    // Last row handed off
                    if (result_taken && (rows_done == num_rows_q - 1'b1)) begin
                        state <= cnn_quad_pkg::ST_JOB_DONE;
                    end
                end
                cnn_quad_pkg::ST_JOB_DONE: begin
                    if (job_complete_ack) begin
                        state <= cnn_quad_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= cnn_quad_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Job parameters captured with the job
    always_ff @(posedge clk_core) begin
        if (job_take) begin
            klen_q     <= job_parameters[cnn_quad_pkg::JOB_KLEN_MSB:cnn_quad_pkg::JOB_KLEN_LSB];
            num_rows_q <= job_parameters[cnn_quad_pkg::JOB_ROWS_MSB:cnn_quad_pkg::JOB_ROWS_LSB];
            relu_en    <= job_parameters[cnn_quad_pkg::JOB_RELU_BIT];
        end
    end

    ////////////////////
    // Fetch handshake
    ////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || job_take) begin
            job_fetch_request <= 1'b0;
            fetch_busy        <= 1'b0;
            rows_requested    <= '0;
            beats_fetched     <= '0;
        end else begin
            if (fetch_go) begin
                job_fetch_request <= 1'b1;
            end else if (job_fetch_request && job_fetch_ack) begin
                job_fetch_request <= 1'b0;
                fetch_busy        <= 1'b1;
                rows_requested    <= rows_requested + 1'b1;
            end
            // Fetch closes on its own beat count
            if (pixel_ready) begin
                if (beats_fetched == klen_q - 1'b1) begin
                    beats_fetched <= '0;
                    fetch_busy    <= 1'b0;
                end else begin
                    beats_fetched <= beats_fetched + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Tap sequencing and result
    ////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || job_take) begin
            pfb_rden     <= 1'b0;
            tap          <= '0;
            row_busy     <= 1'b0;
            first_tap    <= 1'b0;
            last_tap     <= 1'b0;
            last_tap_d   <= 1'b0;
            result_valid <= 1'b0;
            rows_done    <= '0;
        end else begin
            if (row_go) begin
                row_busy <= 1'b1;
                pfb_rden <= 1'b1;
                tap      <= '0;
            end else if (pfb_rden) begin
                if (tap_final) begin
                    pfb_rden <= 1'b0;
                end else begin
                    tap <= tap + 1'b1;
                end
            end

            // Flags move with the data into the engines
            first_tap  <= pfb_rden && (tap == '0);
            last_tap   <= tap_final;
            last_tap_d <= last_tap;

            if (last_tap_d) begin
                result_valid <= 1'b1;
                row_busy     <= 1'b0;
            end else if (result_taken) begin
                result_valid <= 1'b0;
                rows_done    <= rows_done + 1'b1;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    a_accept_from_idle : assert property (@(posedge clk_core) disable iff (rst)
        job_accept |-> (state == cnn_quad_pkg::ST_ACTIVE) && !$past(job_accept));

    a_job_params_legal : assert property (@(posedge clk_core) disable iff (rst)
        job_accept |-> (klen_q != '0)
                    && (klen_q <= cnn_quad_pkg::kernel_len_t'(cnn_quad_pkg::MAX_KERNEL))
                    && (num_rows_q != '0));

    a_tap_in_kernel : assert property (@(posedge clk_core) disable iff (rst)
        pfb_rden |-> cnn_quad_pkg::kernel_len_t'(tap) < klen_q);

endmodule

`default_nettype wire

// File: logic/weight_table.sv
`timescale 1ns/100ps
`default_nettype none

module weight_table (
    input  logic                       clk_core,
    input  logic                       rst,
    input  logic                       load_enable,
    input  logic                       job_accept,
    input  logic                       weight_valid,
    output logic                       weight_ready,
    input  cnn_quad_pkg::weight_word_t weight_data,
    input  cnn_quad_pkg::tap_t         tap,
    output cnn_quad_pkg::weight_word_t weights
);

    cnn_quad_pkg::tap_t load_addr;
    logic               load_beat;

    // Weights are only taken while idle
    assign weight_ready = load_enable && weight_valid;
    assign load_beat    = weight_ready && weight_valid;

    always_ff @(posedge clk_core) begin
        if (rst || job_accept) begin
            load_addr <= '0;
        end else if (load_beat) begin
            if (load_addr == cnn_quad_pkg::tap_t'(cnn_quad_pkg::MAX_KERNEL - 1)) begin
                load_addr <= '0;
            end else begin
                load_addr <= load_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // One kernel memory per engine
    ////////////////////
    for (genvar i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin : g_lane
        cnn_quad_pkg::weight_t mem [cnn_quad_pkg::MAX_KERNEL];

        always_ff @(posedge clk_core) begin
            if (load_beat) begin
                mem[load_addr] <= weight_data[i*cnn_quad_pkg::WEIGHT_WIDTH +:
                                              cnn_quad_pkg::WEIGHT_WIDTH];
            end
            // Registered read lines up with FIFO data
            weights[i*cnn_quad_pkg::WEIGHT_WIDTH +: cnn_quad_pkg::WEIGHT_WIDTH] <= mem[tap];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_cnn_quad -f src.f -o tb_cnn_quad \
    && ./obj_dir/tb_cnn_quad | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: src.f
logic/cnn_quad_pkg.sv
logic/conv_engine.sv
logic/weight_table.sv
logic/prefetch_buffer_fifo.sv
logic/quad_job_ctrl.sv
logic/cnn_quad_top.sv
tb/tb_cnn_quad.sv

// File: tb/tb_cnn_quad.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_quad;

    localparam int CYCLE_LIMIT = 20000;

    logic                       clk_core;
    logic                       rst;
    logic                       job_start;
    logic                       job_accept;
    cnn_quad_pkg::job_params_t  job_parameters;
    logic                       job_fetch_request;
    logic                       job_fetch_ack;
    logic                       job_complete;
    logic                       job_complete_ack;
    logic                       weight_valid;
    logic                       weight_ready;
    cnn_quad_pkg::weight_word_t weight_data;
    logic                       pixel_valid;
    logic                       pixel_ready;
    cnn_quad_pkg::pixel_word_t  pixel_data;
    logic                       result_valid;
    logic                       result_accept;
    cnn_quad_pkg::result_word_t result_data;

    // Reference model state
    logic [31:0]                lcg_state = 32'h39fc;
    cnn_quad_pkg::weight_word_t model_w [cnn_quad_pkg::MAX_KERNEL];
    cnn_quad_pkg::pixel_word_t  pixel_q [$];
    int                         cycle_count = 0;

    cnn_quad_top i_cnn_quad_top (.*);

    always #50 clk_core = ~clk_core;

    ////////////////////
    // Error handling
    ////////////////////
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, got %0b expected %0b",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_result(input cnn_quad_pkg::result_word_t got,
                                input cnn_quad_pkg::result_word_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, got %h expected %h",
                                    $time, what, got, exp));
        end
    endtask

    // Run limit well above the length of all jobs
    always @(posedge clk_core) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_on_error($sformatf("Timeout: no end of the run after %0d cycles", CYCLE_LIMIT));
        end
    end

    ////////////////////
    // Random stimulus
    ////////////////////
    function automatic logic [15:0] next_rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic cnn_quad_pkg::pixel_word_t next_word();
        return {next_rand16(), next_rand16(), next_rand16(), next_rand16()};
    endfunction

    // Mostly negative lanes when ReLU is on
    function automatic cnn_quad_pkg::pixel_word_t make_pixels(input logic neg_bias);
        cnn_quad_pkg::pixel_word_t word;
        word = next_word();
        for (int i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin
            if (neg_bias && ((next_rand16() & 16'h3) != 16'h0)) begin
                word[(i+1)*cnn_quad_pkg::PIXEL_WIDTH-1] = 1'b1;
            end
        end
        return word;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    // Per-lane sum over taps of pixel times weight
    task automatic expected_row(input int klen, input logic relu,
                                output cnn_quad_pkg::result_word_t exp);
        cnn_quad_pkg::pixel_word_t word;
        cnn_quad_pkg::pixel_t      lane_pix;
        cnn_quad_pkg::weight_t     lane_wgt;
        int                        pix;
        int                        sum [cnn_quad_pkg::NUM_CE];
        check_bit(pixel_q.size() >= klen, 1'b1, "pixels of the row sent before its result");
        for (int i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin
            sum[i] = 0;
        end
        for (int k = 0; k < klen; k++) begin
            word = pixel_q.pop_front();
            for (int i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin
                lane_pix = word[i*cnn_quad_pkg::PIXEL_WIDTH +: cnn_quad_pkg::PIXEL_WIDTH];
                lane_wgt = model_w[k][i*cnn_quad_pkg::WEIGHT_WIDTH +: cnn_quad_pkg::WEIGHT_WIDTH];
                pix = lane_pix;
                if (relu && pix < 0) begin
                    pix = 0;
                end
                sum[i] += pix * int'(lane_wgt);
            end
        end
        for (int i = 0; i < cnn_quad_pkg::NUM_CE; i++) begin
            exp[i*cnn_quad_pkg::ACC_WIDTH +: cnn_quad_pkg::ACC_WIDTH] = sum[i];
        end
    endtask

    ////////////////////
    // Test sequences
    ////////////////////
    task automatic check_after_reset();
        @(negedge clk_core);
        check_bit(job_accept, 1'b0, "job_accept after reset");
        check_bit(job_fetch_request, 1'b0, "job_fetch_request after reset");
        check_bit(result_valid, 1'b0, "result_valid after reset");
        check_bit(job_complete, 1'b0, "job_complete after reset");
        check_bit(weight_ready, 1'b0, "weight_ready after reset");
        // Pixels offered with no fetch open
        repeat (3) begin
            pixel_valid = 1'b1;
            #1;
            check_bit(pixel_ready, 1'b0, "pixel_ready with no fetch in progress");
            @(negedge clk_core);
        end
        pixel_valid = 1'b0;
    endtask

    task automatic load_weights(input int klen);
        for (int k = 0; k < klen; k++) begin
            @(negedge clk_core);
            weight_valid = 1'b1;
            weight_data  = next_word();
            #1;
            check_bit(weight_ready, 1'b1, "weight_ready while idle");
            model_w[k] = weight_data;
        end
        @(negedge clk_core);
        weight_valid = 1'b0;
    endtask

    task automatic run_job(input int klen, input int rows, input logic relu, input logic busy);
        cnn_quad_pkg::result_word_t exp;
        cnn_quad_pkg::result_word_t held;
        int                         rows_checked;
        int                         beats_left;
        int                         acks;
        int                         wait_cycles;
        logic                       req_wait;
        logic                       acked;
        logic                       hold;
        rows_checked = 0;
        beats_left   = 0;
        acks         = 0;
        req_wait     = 1'b0;
        acked        = 1'b0;
        hold         = 1'b0;
        held         = '0;
        @(negedge clk_core);
        job_parameters = '0;
        job_parameters[cnn_quad_pkg::JOB_KLEN_MSB:cnn_quad_pkg::JOB_KLEN_LSB] = klen[3:0];
        job_parameters[cnn_quad_pkg::JOB_ROWS_MSB:cnn_quad_pkg::JOB_ROWS_LSB] = rows[7:0];
        job_parameters[cnn_quad_pkg::JOB_RELU_BIT] = relu;
        job_start = 1'b1;
        @(negedge clk_core);
        check_bit(job_accept, 1'b1, "job_accept one cycle after job_start");
        job_start = 1'b0;
        while (rows_checked < rows) begin
            @(negedge clk_core);
            check_bit(job_accept, 1'b0, "job_accept is a single pulse");
            check_bit(job_complete, 1'b0, "job_complete before the last result");
            if (req_wait) begin
                check_bit(job_fetch_request, 1'b1, "fetch request held until ack");
            end
            if (acked) begin
                check_bit(job_fetch_request, 1'b0, "fetch request dropped after ack");
            end
            if (hold) begin
                check_bit(result_valid, 1'b1, "result_valid held until accept");
                check_result(result_data, held, "result_data stable while stalled");
            end
            // Inputs for this cycle
            job_fetch_ack = job_fetch_request && (!busy || (next_rand16() & 16'h3) == 16'h0);
            pixel_valid   = !busy || ((next_rand16() & 16'h3) != 16'h0);
            pixel_data    = make_pixels(relu);
            result_accept = !busy || ((next_rand16() & 16'h1) != 16'h0);
            weight_valid  = (next_rand16() & 16'h1) != 16'h0;
            weight_data   = next_word();
            #1;
            check_bit(weight_ready, 1'b0, "no weight beat taken during a job");
            check_bit(pixel_ready, pixel_valid && (beats_left != 0), "pixel_ready in a fetch");
            if (pixel_ready) begin
                pixel_q.push_back(pixel_data);
                beats_left--;
            end
            if (job_fetch_ack) begin
                beats_left = klen;
                acks++;
            end
            req_wait = job_fetch_request && !job_fetch_ack;
            acked    = job_fetch_ack;
            if (result_valid && result_accept) begin
                expected_row(klen, relu, exp);
                check_result(result_data, exp, $sformatf("row %0d result", rows_checked));
                rows_checked++;
            end
            hold = result_valid && !result_accept;
            held = result_data;
        end
        @(negedge clk_core);
        job_fetch_ack = 1'b0;
        pixel_valid   = 1'b0;
        result_accept = 1'b0;
        weight_valid  = 1'b0;
        check_bit(result_valid, 1'b0, "result_valid low after the last accept");
        check_bit(acks == rows, 1'b1, "one fetch per row");
        check_bit(pixel_q.size() == 0, 1'b1, "no pixels left over");
        wait_cycles = busy ? int'(next_rand16() & 16'h3) : 0;
        repeat (wait_cycles) begin
            check_bit(job_complete, 1'b1, "job_complete held until ack");
            @(negedge clk_core);
        end
        check_bit(job_complete, 1'b1, "job_complete after the last result");
        job_complete_ack = 1'b1;
        @(negedge clk_core);
        check_bit(job_complete, 1'b0, "job_complete dropped after ack");
        job_complete_ack = 1'b0;
    endtask

    initial begin
        clk_core         = 1'b0;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_parameters   = '0;
        job_fetch_ack    = 1'b0;
        job_complete_ack = 1'b0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        result_accept    = 1'b0;
        repeat (2) @(negedge clk_core);
        rst = 1'b0;
        check_after_reset();
        // Single rows with ReLU off then on
        load_weights(4);
        run_job(4, 1, 1'b0, 1'b0);
        load_weights(6);
        run_job(6, 1, 1'b1, 1'b0);
        // Long jobs with random delays, gaps and stalls
        load_weights(5);
        run_job(5, 48, 1'b0, 1'b1);
        load_weights(1);
        run_job(1, 24, 1'b1, 1'b1);
        load_weights(8);
        run_job(8, 24, 1'b0, 1'b1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
